// ==== decodeStage.f ====
+incdir+include
hdl/rv32iPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/immediateExtender.sv
hdl/decodeStage.sv
testbench/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module decodeStageTb -f decodeStage.f

output=$(./obj_dir/VdecodeStageTb)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// ==== testbench/decodeStageTb.sv ====
// Decode stage testbench with clock, reset, vector table, check task and watchdog
`timescale 1ns/10ps
`default_nettype none

`include "decodeConfig_config.svh"

module decodeStageTb
    import rv32iPkg::*;
;
    typedef struct packed {
        logic [31:0] ins;
        logic        we;                    // Writeback strobe
        logic [4:0]  wa;
        logic [31:0] wd;
        logic [15:0] ctl;                   // Expected control word
        logic [15:0] mask;                  // Fields that are defined for the row
        logic [31:0] d1, d2, imm;
        logic        immChk;
    } row_t;

    localparam logic [15:0] maskAll   = 16'hFFFF;
    localparam logic [15:0] maskNoMem = 16'hF1FF;   // memCtrl is free outside loads/stores
    localparam logic [15:0] maskEn    = 16'hF000;   // Only the four enables

    logic CLK = 1'b0, arstN = 1'b0, wbWrEn = 1'b0;
    instrWord_t instr = '0;
    logic [`REG_ADDR_W-1:0] wbAddr = '0, rd, rs1, rs2;
    logic [`XLEN-1:0] wbData = '0, rsData1, rsData2, imm;
    logic regWrEn, memWrEn, jumpEn, branchEn;
    memCtrl_t memCtrl;
    aluOp_t aluOp;
    branchSrc_t branchSrc;
    srcA_t srcA;
    srcB_t srcB;
    resultSrc_t resultSrc;
    logic [15:0] gotCtl;

    row_t vecs[$];
    string tags[$];
    logic [`XLEN-1:0] shadow [`REG_COUNT];   // Model of the register contents
    int seed = 24;
    int checkCount = 0, errCount = 0;
    logic tableReady = 1'b0;

    always #10 CLK = ~CLK;                  // 20 ns period

    decodeStage i_dut (.CLK(CLK), .arstN(arstN), .instr(instr), .wbWrEn(wbWrEn),
        .wbAddr(wbAddr), .wbData(wbData), .regWrEn(regWrEn), .memWrEn(memWrEn),
        .jumpEn(jumpEn), .branchEn(branchEn), .memCtrl(memCtrl), .aluOp(aluOp),
        .branchSrc(branchSrc), .srcA(srcA), .srcB(srcB), .resultSrc(resultSrc),
        .rd(rd), .rs1(rs1), .rs2(rs2), .rsData1(rsData1), .rsData2(rsData2), .imm(imm));

    assign gotCtl = {regWrEn, memWrEn, jumpEn, branchEn, memCtrl, aluOp, branchSrc,
                     srcA, srcB, resultSrc};

    //////////////////////////////////////////////////////////////////////
    // Encoders and expected values
    //////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] ctl(logic rw, logic mw, logic j, logic b, memCtrl_t mc,
        aluOp_t ao, branchSrc_t bs, srcA_t sa, srcB_t sb, resultSrc_t rs);
        return {rw, mw, j, b, mc, ao, bs, sa, sb, rs};
    endfunction

    function automatic logic [31:0] sx12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] im, logic [4:0] r2, logic [4:0] r1,
        logic [2:0] f3);
        return {im[11:5], r2, r1, f3, im[4:0], 7'b0100011};   // Offset split around rs
    endfunction

    function automatic logic [31:0] encB(logic [12:0] im, logic [4:0] r2, logic [4:0] r1,
        logic [2:0] f3);
        return {im[12], im[10:5], r2, r1, f3, im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] im, logic [4:0] rdSel);
        return {im[20], im[10:1], im[11], im[19:12], rdSel, 7'b1101111};
    endfunction

    function automatic logic [31:0] readExp(logic [4:0] a, logic we, logic [4:0] wa,
        logic [31:0] wd);
        if (a == '0)
            return '0;                      // x0 always zero
        if (we && (a == wa))
            return wd;                      // Pending writeback shows this cycle
        return shadow[a];
    endfunction

    task automatic addRow(input string tag, input logic [31:0] ins, input logic we,
        input logic [4:0] wa, input logic [31:0] wd, input logic [15:0] c,
        input logic [15:0] m, input logic [31:0] im, input logic ic);
        row_t v;
        v = '{ins: ins, we: we, wa: wa, wd: wd, ctl: c, mask: m, d1: '0, d2: '0,
              imm: im, immChk: ic};
        v.d1 = readExp(ins[19:15], we, wa, wd);
        v.d2 = readExp(ins[24:20], we, wa, wd);
        vecs.push_back(v);
        tags.push_back(tag);
        if (we && (wa != '0))
            shadow[wa] = wd;                // Committed at the following edge
    endtask

    task automatic addCtl(input string tag, input logic [31:0] ins, input logic [15:0] c,
        input logic [15:0] m, input logic [31:0] im, input logic ic);
        addRow(tag, ins, 1'b0, '0, '0, c, m, im, ic);
    endtask

    task automatic checkVal(input string name, input logic [31:0] got,
        input logic [31:0] expected);
        checkCount++;
        if (got !== expected)
        begin
            errCount++;
            $display("** Error %s: got %h expected %h", name, got, expected);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Vector table
    //////////////////////////////////////////////////////////////////////
    task automatic buildTable();
        aluOp_t aluOfF3 [8];
        logic [2:0] ldF3 [5];
        memCtrl_t ldMc [5];
        logic [2:0] brF3 [6];
        aluOp_t brOp [6];
        logic [11:0] im12;
        logic [15:0] addCtlW;
        aluOfF3 = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
        ldF3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        ldMc = '{MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE_U, MEM_HALF_U};
        brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        brOp = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
        addCtlW = ctl(1, 0, 0, 0, MEM_BYTE, ALU_ADD, BRANCH_PC, SRCA_REG, SRCB_REG, RESULT_ALU);
        for (int i = 0; i < `REG_COUNT; i++)
            shadow[i] = '0;                 // Cleared by reset
        for (int i = 0; i < 32; i++)        // ADD rows read every register after reset
            addCtl("reset", {7'h00, 5'(31 - i), 5'(i), 3'd0, 5'(i), 7'b0110011},
                   addCtlW, maskNoMem, '0, 1'b0);
        for (int i = 0; i < 32; i++)        // Each write forwarded to both ports
            addRow("write", {7'h00, 5'(i), 5'(i), 3'd0, 5'd1, 7'b0110011}, 1'b1, 5'(i),
                   $random(seed), addCtlW, maskNoMem, '0, 1'b0);
        for (int i = 0; i < 32; i++)        // Read back every register including x0
            addCtl("readback", {7'h00, 5'(31 - i), 5'(i), 3'd0, 5'd2, 7'b0110011},
                   addCtlW, maskNoMem, '0, 1'b0);
        for (int f = 0; f < 8; f++)         // R-type group
            addCtl("rtype", {7'h00, 5'(f + 3), 5'(f + 1), 3'(f), 5'(f + 9), 7'b0110011},
                   ctl(1, 0, 0, 0, MEM_BYTE, aluOfF3[f], BRANCH_PC, SRCA_REG, SRCB_REG,
                   RESULT_ALU), maskNoMem, '0, 1'b0);
        addCtl("sub", 32'h40208033, ctl(1, 0, 0, 0, MEM_BYTE, ALU_SUB, BRANCH_PC, SRCA_REG,
               SRCB_REG, RESULT_ALU), maskNoMem, '0, 1'b0);
        addCtl("sra", 32'h4020D033, ctl(1, 0, 0, 0, MEM_BYTE, ALU_SRA, BRANCH_PC, SRCA_REG,
               SRCB_REG, RESULT_ALU), maskNoMem, '0, 1'b0);
        for (int f = 0; f < 8; f++)         // I-type ALU group with plain shamt shifts
        begin
            im12 = (f == 1 || f == 5) ? 12'(f) : ((f % 2 == 0) ? 12'h8A5 : 12'h123);
            addCtl("itype", {im12, 5'(f + 2), 3'(f), 5'(f + 4), 7'b0010011},
                   ctl(1, 0, 0, 0, MEM_BYTE, aluOfF3[f], BRANCH_PC, SRCA_REG, SRCB_IMM,
                   RESULT_ALU), maskNoMem, sx12(im12), 1'b1);
        end
        addCtl("srai", {12'h407, 5'd6, 3'd5, 5'd7, 7'b0010011}, ctl(1, 0, 0, 0, MEM_BYTE,
               ALU_SRA, BRANCH_PC, SRCA_REG, SRCB_IMM, RESULT_ALU), maskNoMem, 32'h407, 1'b1);
        for (int k = 0; k < 5; k++)         // Load address is rs1 + imm
        begin
            im12 = (k % 2 == 0) ? 12'h7FC : 12'hF80;
            addCtl("load", {im12, 5'(k + 10), ldF3[k], 5'(k + 20), 7'b0000011},
                   ctl(1, 0, 0, 0, ldMc[k], ALU_ADD, BRANCH_PC, SRCA_REG, SRCB_IMM,
                   RESULT_ALU), maskAll, sx12(im12), 1'b1);
        end
        for (int k = 0; k < 3; k++)         // Stores
        begin
            im12 = (k % 2 == 0) ? 12'h7F0 : 12'h804;
            addCtl("store", encS(im12, 5'(k + 12), 5'(k + 5), 3'(k)), ctl(0, 1, 0, 0,
                   ldMc[k], ALU_ADD, BRANCH_PC, SRCA_REG, SRCB_IMM, RESULT_ALU), maskAll,
                   sx12(im12), 1'b1);
        end
        for (int k = 0; k < 6; k++)         // Branches with both offset signs
            addCtl("branch", encB((k % 2 == 0) ? 13'h07F4 : 13'h1F0C, 5'(k + 7), 5'(k + 1),
                   brF3[k]), ctl(0, 0, 0, 1, MEM_BYTE, brOp[k], BRANCH_PC, SRCA_REG,
                   SRCB_REG, RESULT_ALU), maskNoMem,
                   (k % 2 == 0) ? 32'h000007F4 : 32'hFFFFFF0C, 1'b1);
        addCtl("lui", 32'hABCDE2B7, ctl(1, 0, 0, 0, MEM_BYTE, ALU_LUI, BRANCH_PC, SRCA_REG,
               SRCB_IMM, RESULT_ALU), maskNoMem, 32'hABCDE000, 1'b1);
        addCtl("lui", 32'h123452B7, ctl(1, 0, 0, 0, MEM_BYTE, ALU_LUI, BRANCH_PC, SRCA_REG,
               SRCB_IMM, RESULT_ALU), maskNoMem, 32'h12345000, 1'b1);
        addCtl("auipc", 32'h7FFFF317, ctl(1, 0, 0, 0, MEM_BYTE, ALU_ADD, BRANCH_PC, SRCA_PC,
               SRCB_IMM, RESULT_ALU), maskNoMem, 32'h7FFFF000, 1'b1);
        addCtl("jal", encJ(21'h0A5A4, 5'd1), ctl(1, 0, 1, 0, MEM_BYTE, ALU_ADD, BRANCH_PC,
               SRCA_REG, SRCB_REG, RESULT_PC4), maskNoMem, 32'h000A5A4, 1'b1);
        addCtl("jal", encJ(21'h1FF8F0, 5'd3), ctl(1, 0, 1, 0, MEM_BYTE, ALU_ADD, BRANCH_PC,
               SRCA_REG, SRCB_REG, RESULT_PC4), maskNoMem, 32'hFFFFF8F0, 1'b1);
        addCtl("jalr", {12'hFFC, 5'd9, 3'd0, 5'd1, 7'b1100111}, ctl(1, 0, 1, 0, MEM_BYTE,
               ALU_ADD, BRANCH_REG, SRCA_REG, SRCB_IMM, RESULT_PC4), maskNoMem,
               32'hFFFFFFFC, 1'b1);
        addCtl("nop-zero", 32'h00000000, '0, maskEn, '0, 1'b0);     // Reset-state word
        addCtl("nop-fence", 32'h0FF0000F, '0, maskEn, '0, 1'b0);
        addCtl("nop-ecall", 32'h00000073, '0, maskEn, '0, 1'b0);
        addCtl("nop-ebreak", 32'h00100073, '0, maskEn, '0, 1'b0);
        addCtl("nop-opcode", 32'h0000007F, '0, maskEn, '0, 1'b0);
        addCtl("nop-branch", encB(13'h0010, 5'd2, 5'd1, 3'b010), '0, maskEn, '0, 1'b0);
        addCtl("nop-store", encS(12'h010, 5'd2, 5'd1, 3'b011), '0, maskEn, '0, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus loop and watchdog
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        int errBefore;
        buildTable();
        tableReady = 1'b1;
        repeat (3) @(posedge CLK);          // Reset held for three cycles
        #2 arstN = 1'b1;
        for (int r = 0; r < vecs.size(); r++)
        begin
            @(posedge CLK);
            #2;                             // Drive just after the edge
            instr  = vecs[r].ins;
            wbWrEn = vecs[r].we;
            wbAddr = vecs[r].wa;
            wbData = vecs[r].wd;
            #17;                            // Sample 1 ns before the next edge
            errBefore = errCount;
            checkVal("ctrl", {16'h0, gotCtl & vecs[r].mask},
                     {16'h0, vecs[r].ctl & vecs[r].mask});
            checkVal("rd", {27'h0, rd}, {27'h0, vecs[r].ins[11:7]});
            checkVal("rs1", {27'h0, rs1}, {27'h0, vecs[r].ins[19:15]});
            checkVal("rs2", {27'h0, rs2}, {27'h0, vecs[r].ins[24:20]});
            checkVal("rsData1", rsData1, vecs[r].d1);
            checkVal("rsData2", rsData2, vecs[r].d2);
            if (vecs[r].immChk)
                checkVal("imm", imm, vecs[r].imm);
            $display("Test %0d %s instr %h: %s", r, tags[r], vecs[r].ins,
                     (errCount == errBefore) ? "ok" : "FAILED");
        end
        $display("Rows %0d, checks %0d, errors %0d", vecs.size(), checkCount, errCount);
        if (errCount == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        wait (tableReady);
        #((vecs.size() + 10) * 20);         // Table length plus reset margin
        $display("Timeout: the vector loop did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
// Decode stage top, instruction field split and block wiring
`timescale 1ns/10ps
`default_nettype none

`include "decodeConfig_config.svh"

module decodeStage
    import rv32iPkg::*;
(
    input  wire                     CLK,
    input  wire                     arstN,
    input  wire instrWord_t         instr,
    input  wire                     wbWrEn,     // Writeback port
    input  wire [`REG_ADDR_W-1:0]   wbAddr,
    input  wire [`XLEN-1:0]         wbData,
    output logic                    regWrEn,    // Control word
    output logic                    memWrEn,
    output logic                    jumpEn,
    output logic                    branchEn,
    output memCtrl_t                memCtrl,
    output aluOp_t                  aluOp,
    output branchSrc_t              branchSrc,
    output srcA_t                   srcA,
    output srcB_t                   srcB,
    output resultSrc_t              resultSrc,
    output logic [`REG_ADDR_W-1:0]  rd,         // Hazard unit
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`XLEN-1:0]        rsData1,
    output logic [`XLEN-1:0]        rsData2,
    output logic [`XLEN-1:0]        imm
);

    immType_t immType;                          // Decoder to extender

    assign rd  = instr.regView.rd;
    assign rs1 = instr.regView.rs1;
    assign rs2 = instr.regView.rs2;

    controlDecoder i_controlDecoder (
        .opcode    (instr.regView.opcode),
        .funct3    (instr.regView.funct3),
        .funct7    (instr.regView.funct7),
        .regWrEn   (regWrEn),
        .memWrEn   (memWrEn),
        .jumpEn    (jumpEn),
        .branchEn  (branchEn),
        .memCtrl   (memCtrl),
        .aluOp     (aluOp),
        .immType   (immType),
        .branchSrc (branchSrc),
        .srcA      (srcA),
        .srcB      (srcB),
        .resultSrc (resultSrc)
    );

    registerFile i_registerFile (
        .CLK     (CLK),
        .arstN   (arstN),
        .wrEn    (wbWrEn),
        .wrAddr  (wbAddr),
        .wrData  (wbData),
        .rdAddrA (instr.regView.rs1),
        .rdAddrB (instr.regView.rs2),
        .rdDataA (rsData1),
        .rdDataB (rsData2)
    );

    immediateExtender i_immediateExtender (
        .instr   (instr),
        .immType (immType),
        .imm     (imm)
    );

endmodule

`default_nettype wire

// ==== hdl/immediateExtender.sv ====
// Immediate extender for the I, S, B, U and J formats
`timescale 1ns/10ps
`default_nettype none

`include "decodeConfig_config.svh"

module immediateExtender
    import rv32iPkg::*;
(
    input  wire instrWord_t     instr,      // Whole word, fields pulled per format
    input  wire immType_t       immType,    // From the control decoder
    output logic [`XLEN-1:0]    imm
);

    always_comb
    begin
        case (immType)
            IMM_I:                                          // inst[31:20]
                imm = {{(`XLEN-12){instr.immView.immHi[11]}}, instr.immView.immHi};
            IMM_S:                                          // inst[31:25], inst[11:7]
                imm = {{(`XLEN-12){instr.regView.funct7[6]}}, instr.regView.funct7,
                       instr.regView.rd};
            IMM_B:                                          // Halfword offset
                imm = {{(`XLEN-12){instr.regView.funct7[6]}},
                       instr.regView.rd[0],                 // imm[11] from inst[7]
                       instr.regView.funct7[5:0],
                       instr.regView.rd[4:1],
                       1'b0};
            IMM_U:                                          // Upper 20, low 12 zero
                imm = {instr.immView.immHi, instr.immView.mid, 12'b0};
            IMM_J:
                imm = {{(`XLEN-20){instr.immView.immHi[11]}},
                       instr.immView.mid,                   // imm[19:12]
                       instr.immView.immHi[0],              // imm[11] from inst[20]
                       instr.immView.immHi[10:1],
                       1'b0};
            default:
                imm = '0;                                   // Unused format codes
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
// Register file with asynchronous clear, x0 guard and write-to-read forwarding
`timescale 1ns/10ps
`default_nettype none

`include "decodeConfig_config.svh"

module registerFile
(
    input  wire                     CLK,
    input  wire                     arstN,
    input  wire                     wrEn,           // Writeback strobe, level
    input  wire [`REG_ADDR_W-1:0]   wrAddr,
    input  wire [`XLEN-1:0]         wrData,
    input  wire [`REG_ADDR_W-1:0]   rdAddrA,        // rs1
    input  wire [`REG_ADDR_W-1:0]   rdAddrB,        // rs2
    output logic [`XLEN-1:0]        rdDataA,
    output logic [`XLEN-1:0]        rdDataB
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 reads zero, then pending writeback data, then the stored word
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wrEn && (addr == wrAddr))
            return wrData;              // Same-cycle forward
        return regs[addr];
    endfunction

    always_ff @(posedge CLK or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;          // Whole array cleared
        end
        else if (wrEn && (wrAddr != '0))
            regs[wrAddr] <= wrData;     // Writes to x0 dropped
    end

    always_comb
    begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

`default_nettype wire

// ==== hdl/controlDecoder.sv ====
// Combinational RV32I control decoder, control word and immediate format
`timescale 1ns/10ps
`default_nettype none

module controlDecoder
    import rv32iPkg::*;
(
    input  wire opcode_t    opcode,
    input  wire [2:0]       funct3,
    input  wire [6:0]       funct7,
    output logic            regWrEn,        // Writeback to rd
    output logic            memWrEn,        // Store
    output logic            jumpEn,
    output logic            branchEn,
    output memCtrl_t        memCtrl,        // Access width and extension
    output aluOp_t          aluOp,
    output immType_t        immType,        // Format for the extender
    output branchSrc_t      branchSrc,
    output srcA_t           srcA,
    output srcB_t           srcB,
    output resultSrc_t      resultSrc
);

    logic legal;                            // Pattern within supported RV32I set

    //////////////////////////////////////////////////////////////////////
    // Legality check per opcode
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (opcode)
            OP_R:
                legal = (funct7 == F7_BASE) ||
                        ((funct7 == F7_ALT) && (funct3 inside {F3_ADD_SUB, F3_SRL_SRA}));
            OP_I:
            begin
                case (funct3)
                    F3_SLL:     legal = (funct7 == F7_BASE);                  // SLLI
                    F3_SRL_SRA: legal = (funct7 inside {F7_BASE, F7_ALT});    // SRLI/SRAI
                    default:    legal = 1'b1;
                endcase
            end
            OP_LOAD:   legal = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
            OP_STORE:  legal = funct3 inside {F3_SB, F3_SH, F3_SW};
            OP_BRANCH: legal = !(funct3 inside {3'b010, 3'b011});         // Two holes
            OP_JALR:   legal = (funct3 == F3_JALR);
            OP_JAL, OP_LUI, OP_AUIPC:
                legal = 1'b1;                                              // No funct fields
            default:   legal = 1'b0;   // FENCE, SYSTEM and unknown opcodes stay as no-ops
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        regWrEn   = 1'b0;                   // No architectural side effects
        memWrEn   = 1'b0;
        jumpEn    = 1'b0;
        branchEn  = 1'b0;
        memCtrl   = MEM_BYTE;
        aluOp     = ALU_ADD;
        immType   = IMM_I;
        branchSrc = BRANCH_PC;
        srcA      = SRCA_REG;
        srcB      = SRCB_REG;
        resultSrc = RESULT_ALU;

        if (legal)
        begin
            case (opcode)
                OP_R:
                begin
                    regWrEn = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
                        F3_SLL:     aluOp = ALU_SLL;
                        F3_SLT:     aluOp = ALU_SLT;
                        F3_SLTU:    aluOp = ALU_SLTU;
                        F3_XOR:     aluOp = ALU_XOR;
                        F3_SRL_SRA: aluOp = funct7[5] ? ALU_SRA : ALU_SRL;
                        F3_OR:      aluOp = ALU_OR;
                        default:    aluOp = ALU_AND;
                    endcase
                end
                OP_I, OP_LOAD:
                begin
                    regWrEn = 1'b1;
                    srcB    = SRCB_IMM;             // rs1 + imm
                    case (funct3)                   // Same funct3 feeds aluOp and memCtrl
                        F3_ADD_SUB: memCtrl = MEM_BYTE;
                        F3_SLL:
                        begin
                            aluOp   = ALU_SLL;
                            memCtrl = MEM_HALF;
                        end
                        F3_SLT:
                        begin
                            aluOp   = ALU_SLT;
                            memCtrl = MEM_WORD;
                        end
                        F3_SLTU:    aluOp = ALU_SLTU;
                        F3_XOR:
                        begin
                            aluOp   = ALU_XOR;
                            memCtrl = MEM_BYTE_U;
                        end
                        F3_SRL_SRA:
                        begin
                            aluOp   = funct7[5] ? ALU_SRA : ALU_SRL;
                            memCtrl = MEM_HALF_U;
                        end
                        F3_OR:      aluOp = ALU_OR;
                        default:    aluOp = ALU_AND;
                    endcase
                    if (opcode == OP_LOAD)
                        aluOp = ALU_ADD;            // Load address is always an add
                end
                OP_JALR:
                begin
                    regWrEn   = 1'b1;
                    jumpEn    = 1'b1;
                    srcB      = SRCB_IMM;
                    branchSrc = BRANCH_REG;         // Target from rs1
                    resultSrc = RESULT_PC4;         // Link address
                end
                OP_STORE:
                begin
                    memWrEn = 1'b1;
                    srcB    = SRCB_IMM;
                    immType = IMM_S;
                    case (funct3)
                        F3_SB:   memCtrl = MEM_BYTE;
                        F3_SH:   memCtrl = MEM_HALF;
                        default: memCtrl = MEM_WORD;
                    endcase
                end
                OP_BRANCH:
                begin
                    branchEn = 1'b1;                // Compare rs1 against rs2
                    immType  = IMM_B;
                    case (funct3)
                        F3_BEQ:  aluOp = ALU_BEQ;
                        F3_BNE:  aluOp = ALU_BNE;
                        F3_BLT:  aluOp = ALU_BLT;
                        F3_BGE:  aluOp = ALU_BGE;
                        F3_BLTU: aluOp = ALU_BLTU;
                        default: aluOp = ALU_BGEU;
                    endcase
                end
                OP_LUI, OP_AUIPC:
                begin
                    regWrEn = 1'b1;
                    srcB    = SRCB_IMM;
                    immType = IMM_U;
                    aluOp   = (opcode == OP_AUIPC) ? ALU_ADD : ALU_LUI;
                    srcA    = (opcode == OP_AUIPC) ? SRCA_PC : SRCA_REG;   // PC + upper imm
                end
                OP_JAL:
                begin
                    regWrEn   = 1'b1;
                    jumpEn    = 1'b1;
                    immType   = IMM_J;              // PC-relative target
                    resultSrc = RESULT_PC4;
                end
                default: ;                          // Unreachable, legal is low
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv32iPkg.sv ====
// RV32I instruction union, opcode and funct encodings, decode control types
`default_nettype none

package rv32iPkg;

`include "decodeConfig_config.svh"

    //////////////////////////////////////////////////////////////////////
    // Base opcodes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,         // Register-register ALU
        OP_I      = 7'b0010011,         // Register-immediate ALU
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_FENCE  = 7'b0001111,         // FENCE and PAUSE
        OP_SYSTEM = 7'b1110011          // ECALL and EBREAK
    } opcode_t;

    // Instruction word, register view and immediate view of the same bits
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            opcode_t                opcode;
        } regView;
        struct packed {
            logic [11:0]            immHi;    // Bits 31..20
            logic [7:0]             mid;      // Bits 19..12
            logic [4:0]             lowBits;  // Bits 11..7, rd position
            opcode_t                opcode;
        } immView;
    } instrWord_t;

    //////////////////////////////////////////////////////////////////////
    // funct3 / funct7 field values
    //////////////////////////////////////////////////////////////////////
    localparam logic [2:0] F3_ADD_SUB = 3'b000;   // ALU group, R and I
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LB      = 3'b000;   // Loads
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;   // Stores
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;   // Branches
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB, SRA, SRAI

    //////////////////////////////////////////////////////////////////////
    // Control word encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_BLT, ALU_BLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_BEQ, ALU_BNE, ALU_BGE, ALU_BGEU, ALU_LUI
    } aluOp_t;
    localparam aluOp_t ALU_SLT  = ALU_BLT;    // Set-less-than reuses the compare
    localparam aluOp_t ALU_SLTU = ALU_BLTU;

    typedef enum logic [2:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_BYTE_U, MEM_HALF_U} memCtrl_t;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immType_t;
    typedef enum logic [1:0] {RESULT_ALU, RESULT_PC4} resultSrc_t;   // 2 and 3 unused
    typedef enum logic {SRCA_REG, SRCA_PC} srcA_t;
    typedef enum logic {SRCB_REG, SRCB_IMM} srcB_t;
    typedef enum logic {BRANCH_PC, BRANCH_REG} branchSrc_t;           // Target base

endpackage

`default_nettype wire

// ==== include/decodeConfig_config.svh ====
// Word width, register count and register address width for the decode stage
`ifndef DECODECONFIG_CONFIG_SVH
`define DECODECONFIG_CONFIG_SVH

// Datapath word
`define XLEN 32                         // RV32I data and instruction width

// Architectural register file
`define REG_COUNT 32                    // x0..x31
`define REG_ADDR_W 5                    // log2 of REG_COUNT

`endif
